// ==== hw/rvCtrlPkg.sv ====
package rvCtrlPkg;

    // ALU operation as seen by the execute stage
    // Encoding is local to this datapath, not taken from the ISA
    typedef enum logic [3:0] {
        // Two's complement sum, also used for store addresses
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        // Shifts use the low five bits of operand B
        aluSll   = 4'd2,
        // Set-less-than, signed and unsigned
        aluSlt   = 4'd3,
        aluSltu  = 4'd4,
        aluXor   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluOr    = 4'd8,
        aluAnd   = 4'd9,
        // Operand B straight through, for LUI
        aluPassB = 4'd10
    } aluOpT;

endpackage

// ==== hw/rvDecode.sv ====
module rvDecode (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               instrValid,
    input  logic [rvIsaPkg::xLen-1:0]          instr,
    output logic                               decValid,
    output logic                               illegal,
    output logic [rvIsaPkg::regAddrWidth-1:0]  rs1,
    output logic [rvIsaPkg::regAddrWidth-1:0]  rs2,
    output logic [rvIsaPkg::regAddrWidth-1:0]  rd,
    output logic [rvIsaPkg::xLen-1:0]          imm,
    output logic                               aluSrc,
    output rvCtrlPkg::aluOpT                   aluOp,
    output logic                               regWrite,
    output logic                               memWrite
);

    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    // Stage register, raw word plus its valid bit
    logic [xLen-1:0]        instrQ;
    logic                   validQ;

    // Instruction fields
    logic [opcodeWidth-1:0] opcode;
    logic [2:0]             func3;
    logic [6:0]             func7;

    // Raw decode before the illegal and valid qualification
    logic                   writesReg;
    logic                   writesMem;
    logic                   badInstr;

    // Valid bit is control state, word is payload only
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            validQ <= 1'b0;
        else
            validQ <= instrValid;
    end

    // Hold the word only when a new one is offered
    always_ff @(posedge clk)
    begin
        if (instrValid)
            instrQ <= instr;
    end

    // Fixed field positions shared by all formats
    assign opcode = instrQ[6:0];
    assign rd     = instrQ[11:7];
    assign func3  = instrQ[14:12];
    assign rs1    = instrQ[19:15];
    assign rs2    = instrQ[24:20];
    assign func7  = instrQ[31:25];

    always_comb
    begin
        // Defaults describe a bubble
        imm       = '0;
        aluSrc    = 1'b0;
        aluOp     = aluAdd;
        writesReg = 1'b0;
        writesMem = 1'b0;
        badInstr  = 1'b0;

        case (opcode)
            opLui:
            begin
                // U format, upper twenty bits, low twelve zero
                imm       = {instrQ[31:12], 12'b0};
                aluSrc    = 1'b1;
                aluOp     = aluPassB;
                writesReg = 1'b1;
            end

            opImm:
            begin
                // I format, sign-extended; shamt sits in imm[4:0]
                imm       = {{20{instrQ[31]}}, instrQ[31:20]};
                aluSrc    = 1'b1;
                writesReg = 1'b1;
                case (func3)
                    f3AddSub: aluOp = aluAdd;
                    f3Sll:    aluOp = aluSll;
                    f3Slt:    aluOp = aluSlt;
                    f3Sltu:   aluOp = aluSltu;
                    f3Xor:    aluOp = aluXor;
                    // SRAI vs SRLI from func7
                    f3SrlSra: aluOp = (func7 == f7Alt) ? aluSra : aluSrl;
                    f3Or:     aluOp = aluOr;
                    default:  aluOp = aluAnd;
                endcase
            end

            opReg:
            begin
                writesReg = 1'b1;
                case (func3)
                    f3AddSub: aluOp = (func7 == f7Alt) ? aluSub : aluAdd;
                    f3Sll:    aluOp = aluSll;
                    f3Slt:    aluOp = aluSlt;
                    f3Sltu:   aluOp = aluSltu;
                    f3Xor:    aluOp = aluXor;
                    f3SrlSra: aluOp = (func7 == f7Alt) ? aluSra : aluSrl;
                    f3Or:     aluOp = aluOr;
                    default:  aluOp = aluAnd;
                endcase
                // Only zero, or the alternate code on ADD/SUB and SRL/SRA
                if (func7 == f7Alt)
                    badInstr = (func3 != f3AddSub) && (func3 != f3SrlSra);
                else
                    badInstr = (func7 != 7'b0);
            end

            opStore:
            begin
                // S format, immediate split around rd field
                imm       = {{20{instrQ[31]}}, instrQ[31:25], instrQ[11:7]};
                aluSrc    = 1'b1;
                aluOp     = aluAdd;
                writesMem = 1'b1;
                // Byte and halfword stores not carried
                badInstr  = (func3 != f3Sw);
            end

            default:
                badInstr = 1'b1;
        endcase
    end

    // Qualify by the stage valid; an illegal word has no side effect
    assign decValid = validQ;
    assign illegal  = validQ && badInstr;
    assign regWrite = validQ && writesReg && !badInstr;
    assign memWrite = validQ && writesMem && !badInstr;

endmodule

// ==== hw/rvExecCore.sv ====
module rvExecCore (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               instrValid,
    input  logic [rvIsaPkg::xLen-1:0]          instr,
    output logic                               wbValid,
    output logic [rvIsaPkg::regAddrWidth-1:0]  wbRd,
    output logic [rvIsaPkg::xLen-1:0]          wbData,
    output logic                               storeValid,
    output logic [rvIsaPkg::xLen-1:0]          storeAddr,
    output logic [rvIsaPkg::xLen-1:0]          storeData,
    output logic                               illegal
);

    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    // Decode stage outputs
    logic                    decValid;
    logic [regAddrWidth-1:0] rs1;
    logic [regAddrWidth-1:0] rs2;
    logic [regAddrWidth-1:0] rd;
    logic [xLen-1:0]         imm;
    logic                    aluSrc;
    aluOpT                   aluOp;
    logic                    regWrite;
    logic                    memWrite;

    // Register file read data
    logic [xLen-1:0]         rs1Data;
    logic [xLen-1:0]         rs2Data;

    // Write port back from execute
    logic                    wrEn;
    logic [regAddrWidth-1:0] wrAddr;
    logic [xLen-1:0]         wrData;

    rvDecode decodeInst (
        .clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
        .decValid(decValid), .illegal(illegal), .rs1(rs1), .rs2(rs2), .rd(rd),
        .imm(imm), .aluSrc(aluSrc), .aluOp(aluOp),
        .regWrite(regWrite), .memWrite(memWrite)
    );

    // Read during the decode cycle, no forwarding path
    rvRegFile regFileInst (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    rvExecute executeInst (
        .clk(clk), .rst(rst), .decValid(decValid), .rd(rd), .imm(imm),
        .aluSrc(aluSrc), .aluOp(aluOp), .regWrite(regWrite), .memWrite(memWrite),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
    );

endmodule

// ==== hw/rvExecute.sv ====
module rvExecute (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               decValid,
    input  logic [rvIsaPkg::regAddrWidth-1:0]  rd,
    input  logic [rvIsaPkg::xLen-1:0]          imm,
    input  logic                               aluSrc,
    input  rvCtrlPkg::aluOpT                   aluOp,
    input  logic                               regWrite,
    input  logic                               memWrite,
    input  logic [rvIsaPkg::xLen-1:0]          rs1Data,
    input  logic [rvIsaPkg::xLen-1:0]          rs2Data,
    output logic                               wrEn,
    output logic [rvIsaPkg::regAddrWidth-1:0]  wrAddr,
    output logic [rvIsaPkg::xLen-1:0]          wrData,
    output logic                               wbValid,
    output logic [rvIsaPkg::regAddrWidth-1:0]  wbRd,
    output logic [rvIsaPkg::xLen-1:0]          wbData,
    output logic                               storeValid,
    output logic [rvIsaPkg::xLen-1:0]          storeAddr,
    output logic [rvIsaPkg::xLen-1:0]          storeData
);

    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    logic [xLen-1:0] opB;
    logic [xLen-1:0] aluResult;
    logic [4:0]      shamt;

    // Immediate for I, U and S formats
    assign opB   = aluSrc ? imm : rs2Data;
    assign shamt = opB[4:0];

    always_comb
    begin
        case (aluOp)
            aluAdd:   aluResult = rs1Data + opB;
            aluSub:   aluResult = rs1Data - opB;
            aluSll:   aluResult = rs1Data << shamt;
            aluSlt:   aluResult = {31'b0, $signed(rs1Data) < $signed(opB)};
            aluSltu:  aluResult = {31'b0, rs1Data < opB};
            aluXor:   aluResult = rs1Data ^ opB;
            aluSrl:   aluResult = rs1Data >> shamt;
            // Arithmetic shift keeps the sign bit
            aluSra:   aluResult = $unsigned($signed(rs1Data) >>> shamt);
            aluOr:    aluResult = rs1Data | opB;
            aluAnd:   aluResult = rs1Data & opB;
            aluPassB: aluResult = opB;
            default:  aluResult = '0;
        endcase
    end

    // Register file write, taken at the next edge
    assign wrEn   = decValid && regWrite;
    assign wrAddr = rd;
    assign wrData = aluResult;

    // Output strobes, cleared by reset
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wbValid    <= 1'b0;
            storeValid <= 1'b0;
        end
        else
        begin
            wbValid    <= decValid && regWrite;
            storeValid <= decValid && memWrite;
        end
    end

    // Payload only loads alongside its strobe
    always_ff @(posedge clk)
    begin
        if (decValid && regWrite)
        begin
            wbRd   <= rd;
            wbData <= aluResult;
        end
        // ALU sum is rs1 plus the S immediate
        if (decValid && memWrite)
        begin
            storeAddr <= aluResult;
            storeData <= rs2Data;
        end
    end

    // Decode never flags both, so the two ports stay exclusive
    aOneStrobe: assert property (@(posedge clk) disable iff (rst)
        !(wbValid && storeValid))
        else $error("wbValid and storeValid both set");

endmodule

// ==== hw/rvIsaPkg.sv ====
package rvIsaPkg;

    // Base integer width for data and instruction words
    localparam int xLen = 32;

    // Register index width, 32 architectural registers
    localparam int regAddrWidth = 5;

    // Major opcode field
    localparam int opcodeWidth = 7;

    // Opcodes of the kept instruction classes
    localparam logic [opcodeWidth-1:0] opLui   = 7'b0110111;
    localparam logic [opcodeWidth-1:0] opImm   = 7'b0010011;
    localparam logic [opcodeWidth-1:0] opReg   = 7'b0110011;
    localparam logic [opcodeWidth-1:0] opStore = 7'b0100011;

    // Shared func3 codes of OP and OP-IMM
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // Word store, the only store width kept
    localparam logic [2:0] f3Sw = 3'b010;

    // Alternate func7, picks SUB over ADD and SRA over SRL
    localparam logic [6:0] f7Alt = 7'b0100000;

endpackage

// ==== hw/rvRegFile.sv ====
module rvRegFile (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [rvIsaPkg::regAddrWidth-1:0]  rs1,
    input  logic [rvIsaPkg::regAddrWidth-1:0]  rs2,
    input  logic                               wrEn,
    input  logic [rvIsaPkg::regAddrWidth-1:0]  wrAddr,
    input  logic [rvIsaPkg::xLen-1:0]          wrData,
    output logic [rvIsaPkg::xLen-1:0]          rs1Data,
    output logic [rvIsaPkg::xLen-1:0]          rs2Data
);

    import rvIsaPkg::*;

    // x1 to x31 only, x0 has no storage
    logic [xLen-1:0] regs [1:31];

    // Write commits at the edge that ends the decode cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wrEn && (wrAddr != '0))
        begin
            regs[wrAddr] <= wrData;
        end
    end

    // Combinational reads, x0 hardwired to zero
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

    // Next decode read of the written register sees the new value
    aWriteReadBack: assert property (@(posedge clk) disable iff (rst)
        (wrEn && (wrAddr != '0)) |=>
            ((rs1 != $past(wrAddr)) || (rs1Data == $past(wrData))))
        else $error("register read missed the previous write");

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then judge the log
verilator --binary --timing --assert --top-module rvExecCoreTb -f rvExecCore.f -o simv \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; } || exit 0

// ==== rvExecCore.f ====
+incdir+include
hw/rvIsaPkg.sv
hw/rvCtrlPkg.sv
hw/rvDecode.sv
hw/rvRegFile.sv
hw/rvExecute.sv
hw/rvExecCore.sv
test/rvExecCoreTb.sv

// ==== include/rvTbModel.svh ====
`ifndef RV_TB_MODEL_SVH
`define RV_TB_MODEL_SVH

// Shadow copy of the architectural registers
logic [31:0] modelRegs [0:31] = '{default: '0};

// Expected strobes, each tagged with the cycle it is due in
int          wbDue[$];
logic [31:0] wbRdQ[$];
logic [31:0] wbDataQ[$];
int          stDue[$];
logic [31:0] stAddrQ[$];
logic [31:0] stDataQ[$];
int          illDue[$];

// Opcodes outside the kept set
localparam logic [6:0] badOps [0:6] = '{7'h03, 7'h63, 7'h6f, 7'h67, 7'h17, 7'h0f, 7'h73};

// Encoders, one per format
function automatic logic [31:0] buildR(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opReg};
endfunction

function automatic logic [31:0] buildI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, opImm};
endfunction

// Immediate split around the rd slot
function automatic logic [31:0] buildS(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, f3Sw, imm[4:0], opStore};
endfunction

function automatic logic [31:0] buildU(input logic [19:0] upper, input logic [4:0] rd);
    return {upper, rd, opLui};
endfunction

// RV32I integer result by func3, alt selects SUB and SRA
function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0: return alt ? (a - b) : (a + b);
        3'd1: return a << b[4:0];
        // Differing signs decide on their own
        3'd2: return (a[31] != b[31]) ? {31'b0, a[31]} : ((a < b) ? 32'd1 : 32'd0);
        3'd3: return (a < b) ? 32'd1 : 32'd0;
        3'd4: return a ^ b;
        3'd5:
        begin
            // Sign fill only for the arithmetic form
            if (alt)
                return (a >> b[4:0]) | ({32{a[31]}} << (32 - int'(b[4:0])));
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// Writeback due two cycles after issue
task automatic expectWb(input logic [4:0] rd, input logic [31:0] data);
    wbDue.push_back(cycle + 2);
    wbRdQ.push_back(32'(rd));
    wbDataQ.push_back(data);
    // Port shows x0 results, the register stays zero
    if (rd != 5'd0)
        modelRegs[rd] = data;
endtask

task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
    stDue.push_back(cycle + 2);
    stAddrQ.push_back(addr);
    stDataQ.push_back(data);
endtask

`endif

// ==== test/rvExecCoreTb.sv ====
module rvExecCoreTb;

    import rvIsaPkg::*;

    logic        clk = 1'b0;
    logic        rst;
    logic        instrValid;
    logic [31:0] instr;
    logic        wbValid;
    logic [4:0]  wbRd;
    logic [31:0] wbData;
    logic        storeValid;
    logic [31:0] storeAddr;
    logic [31:0] storeData;
    logic        illegal;

    int seed = 83;
    // Edges seen since time zero
    int cycle = 0;

    `include "rvTbModel.svh"

    rvExecCore rvExecCore_i (
        .clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData),
        .illegal(illegal)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic failWith(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // Mostly x0 to x7, so later instructions read recent results
    function automatic logic [4:0] pickReg(input int r);
        if (r[7:5] != 3'd0)
            return {2'b00, r[2:0]};
        return r[4:0];
    endfunction

    task automatic issueRandom();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [2:0]  idx;
        logic [31:0] word;
        logic [31:0] rnd;
        int          kind;
        rd   = pickReg($random(seed));
        rs1  = pickReg($random(seed));
        rs2  = pickReg($random(seed));
        f3   = 3'($random(seed));
        alt  = 1'($random(seed));
        imm  = 12'($random(seed));
        rnd  = $random(seed);
        kind = $unsigned($random(seed)) % 10;
        if (kind < 4)
        begin
            // Alternate func7 only on ADD/SUB and SRL/SRA
            alt  = alt && (f3 == 3'd0 || f3 == 3'd5);
            word = buildR(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
            expectWb(rd, aluModel(f3, alt, modelRegs[rs1], modelRegs[rs2]));
        end
        else if (kind < 7)
        begin
            // Shift immediates carry func7 in imm[11:5]
            alt = alt && (f3 == 3'd5);
            if (f3 == 3'd1 || f3 == 3'd5)
                imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
            word = buildI(imm, rs1, f3, rd);
            expectWb(rd, aluModel(f3, alt, modelRegs[rs1], {{20{imm[11]}}, imm}));
        end
        else if (kind == 7)
        begin
            // Upper twenty bits, low twelve zero
            rnd[11:0] = 12'h000;
            word = buildU(rnd[31:12], rd);
            expectWb(rd, rnd);
        end
        else if (kind == 8)
        begin
            word = buildS(imm, rs2, rs1);
            expectStore(modelRegs[rs1] + {{20{imm[11]}}, imm}, modelRegs[rs2]);
        end
        else
        begin
            // Unknown opcode, or R-type with a func7 outside the base set
            idx  = 3'($unsigned($random(seed)) % 7);
            word = alt ? buildR(7'h01, rs2, rs1, f3, rd) : {rnd[31:7], badOps[idx]};
            illDue.push_back(cycle + 1);
        end
        instrValid = 1'b1;
        instr      = word;
    endtask

    // Sampled mid-cycle, away from both edges
    always @(negedge clk)
    begin
        if (wbDue.size() > 0 && wbDue[0] == cycle)
        begin
            if (!wbValid)
                failWith("expected writeback strobe did not appear");
            else
            begin
                checkValue("wbRd", wbRdQ.pop_front(), 32'(wbRd));
                checkValue("wbData", wbDataQ.pop_front(), wbData);
                void'(wbDue.pop_front());
            end
        end
        else
            checkValue("wbValid idle", 32'd0, 32'(wbValid));
        if (stDue.size() > 0 && stDue[0] == cycle)
        begin
            if (!storeValid)
                failWith("expected store strobe did not appear");
            else
            begin
                checkValue("storeAddr", stAddrQ.pop_front(), storeAddr);
                checkValue("storeData", stDataQ.pop_front(), storeData);
                void'(stDue.pop_front());
            end
        end
        else
            checkValue("storeValid idle", 32'd0, 32'(storeValid));
        if (illDue.size() > 0 && illDue[0] == cycle)
        begin
            if (!illegal)
                failWith("illegal strobe missing for an unsupported instruction");
            else
                void'(illDue.pop_front());
        end
        else
            checkValue("illegal idle", 32'd0, 32'(illegal));
    end

    initial
    begin
        int gap;
        int waitCount;
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        gap        = 0;
        waitCount  = 0;
        for (int i = 0; i < 8; i++)
            @(posedge clk);
        #2;
        rst = 1'b0;
        for (int n = 0; n < 600; n++)
        begin
            @(posedge clk);
            #2;
            if (gap > 0)
            begin
                instrValid = 1'b0;
                gap--;
            end
            else
            begin
                issueRandom();
                // Half back to back, else up to three idle cycles
                gap = ($random(seed) & 1) ? 0 : ($unsigned($random(seed)) % 4);
            end
        end
        @(posedge clk);
        #2;
        instrValid = 1'b0;
        // Drain whatever is still in flight
        while ((wbDue.size() + stDue.size() + illDue.size()) > 0 && waitCount < 20)
        begin
            @(posedge clk);
            waitCount++;
        end
        if ((wbDue.size() + stDue.size() + illDue.size()) > 0)
            failWith("timed out waiting for outstanding results");
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule
